/* logic/frame_proto_pkg.sv */
package frame_proto_pkg;

    // Host to device start-of-frame marker
    localparam logic [7:0] sof_host = 8'hA5;

    // Status codes returned with every parsed frame
    typedef enum logic [7:0] {
        status_ok      = 8'h00,
        status_crc_err = 8'h01, // CRC byte did not match
        status_cmd_inv = 8'h02, // Reserved size in command
        status_timeout = 8'h04  // Byte gap too long inside a frame
    } status_t;

    // Transfer size field of the command byte
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10,
        size_rsvd = 2'b11 // Not supported, flagged as invalid command
    } size_t;

    // Command byte broken into its fields, MSB first
    typedef struct packed {
        logic       rw;   // 1 = read, 0 = write
        logic       inc;  // Address increments per beat
        size_t      size; // Beat size
        logic [3:0] len;  // Beat count minus one
    } cmd_fields_t;

    // Same command byte seen raw (CRC, output) or as fields (decode)
    typedef union packed {
        logic [7:0]  raw;
        cmd_fields_t f;
    } cmd_t;

endpackage

/* logic/parser_cfg_pkg.sv */
package parser_cfg_pkg;

    // Receive walk of one host frame
    typedef enum logic [3:0] {
        idle,    // Hunting for the start byte
        cmd,
        addr0,   // Address LSB
        addr1,
        addr2,
        addr3,   // Address MSB
        data_rx, // Payload bytes
        crc_rx,
        done,    // Result held for the consumer
        error    // Timeout result held for the consumer
    } parser_state_t;

    localparam int buf_depth = 64; // Max payload, 16 words
    localparam int buf_idx_w = 6;  // Index into the payload buffer
    localparam int count_w   = 7;  // Data count, must reach 64

endpackage

/* logic/crc8_calc.sv */
`timescale 1ns/1ps

module crc8_calc (
    input  logic       clk,
    input  logic       rst,
    input  logic       crc_clear, // Start of a new frame
    input  logic       crc_en,    // Fold data_in this cycle
    input  logic [7:0] data_in,
    output logic [7:0] crc
);

    logic [7:0] crc_next;

    // One byte through x^8 + x^2 + x + 1, MSB first
    always_comb begin
        crc_next = crc ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) crc_next = {crc_next[6:0], 1'b0} ^ 8'h07;
            else             crc_next = {crc_next[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc <= 8'h00; // Init value 00h
        end else if (crc_en) begin
            crc <= crc_next;
        end
    end

    // Start byte is never part of the CRC, so clear and fold cannot overlap
    a_clear_not_en: assert property (@(posedge clk) disable iff (rst)
        !(crc_clear && crc_en));

endmodule

/* logic/byte_gap_timer.sv */
`timescale 1ns/1ps

module byte_gap_timer #(
    parameter int timeout_clocks = 0 // 0 disables the timer
) (
    input  logic clk,
    input  logic rst,
    input  logic frame_open, // FSM is inside a frame
    input  logic fifo_empty,
    output logic timed_out
);

    localparam int cnt_w = (timeout_clocks > 0) ? $clog2(timeout_clocks + 1) : 1;
    localparam logic [cnt_w-1:0] limit = timeout_clocks[cnt_w-1:0];

    logic [cnt_w-1:0] gap_cnt; // Consecutive starved cycles

    always_ff @(posedge clk) begin
        if (rst || !frame_open || !fifo_empty || timed_out) begin
            gap_cnt <= '0; // Any byte or closed frame restarts the gap
        end else if (gap_cnt != limit) begin
            gap_cnt <= gap_cnt + 1'b1; // Saturates at the limit
        end
    end

    assign timed_out = (timeout_clocks != 0) && (gap_cnt == limit);

    // Count only builds while open, and the FSM leaves the frame
    // the same edge the timeout clears the count
    a_timeout_in_frame: assert property (@(posedge clk) disable iff (rst)
        timed_out |-> frame_open);

endmodule

/* logic/frame_data_buffer.sv */
`timescale 1ns/1ps

module frame_data_buffer (
    input  logic                                 clk,
    input  logic                                 wr_en,
    input  logic [parser_cfg_pkg::buf_idx_w-1:0] wr_idx,
    input  logic [7:0]                           wr_data,
    input  logic [parser_cfg_pkg::buf_idx_w-1:0] rd_idx,
    output logic [7:0]                           rd_data
);

    // Payload store, one byte per entry
    logic [7:0] mem [parser_cfg_pkg::buf_depth];

    // Written once per payload byte as the FSM takes it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Consumer side read, no latency
    assign rd_data = mem[rd_idx];

endmodule

/* logic/frame_parser_fsm.sv */
`timescale 1ns/1ps

module frame_parser_fsm (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [7:0]                            rx_fifo_data,
    input  logic                                  rx_fifo_empty,
    output logic                                  rx_fifo_rd_en,
    output logic                                  crc_clear,
    output logic                                  crc_en,
    input  logic [7:0]                            crc_calc,
    output logic                                  buf_wr_en,
    output logic [parser_cfg_pkg::buf_idx_w-1:0]  buf_wr_idx,
    output logic                                  frame_open,
    input  logic                                  timed_out,
    output frame_proto_pkg::cmd_t                 cmd,
    output logic [31:0]                           addr,
    output logic [parser_cfg_pkg::count_w-1:0]    data_count,
    output frame_proto_pkg::status_t              error_status,
    output logic                                  frame_valid,
    output logic                                  frame_error,
    input  logic                                  frame_consumed,
    output logic                                  parser_busy
);

    localparam int cw = parser_cfg_pkg::count_w;

    parser_cfg_pkg::parser_state_t state, state_next;

    frame_proto_pkg::cmd_t    cmd_in;     // FIFO byte read as a command
    frame_proto_pkg::status_t crc_status; // Verdict if this byte is the CRC
    logic [cw-1:0]            len_plus1;
    logic [cw-1:0]            len_calc;   // Payload length of cmd_in
    logic [cw-1:0]            exp_len;    // Payload length of the held command
    logic                     take;       // Byte consumed this cycle

    assign cmd_in.raw = rx_fifo_data;

    // Receive states pull a byte whenever one is there
    always_comb begin
        unique case (state)
            parser_cfg_pkg::done, parser_cfg_pkg::error: take = 1'b0;
            default: take = !rx_fifo_empty;
        endcase
    end

    assign frame_open  = (state != parser_cfg_pkg::idle) && (state != parser_cfg_pkg::done)
                         && (state != parser_cfg_pkg::error);
    assign parser_busy = (state != parser_cfg_pkg::idle);

    assign rx_fifo_rd_en = take; // Junk in idle is also read and dropped
    assign crc_clear = take && (state == parser_cfg_pkg::idle)
                       && (rx_fifo_data == frame_proto_pkg::sof_host);
    assign crc_en    = take && frame_open && (state != parser_cfg_pkg::crc_rx);
    assign buf_wr_en = take && (state == parser_cfg_pkg::data_rx);
    assign buf_wr_idx = data_count[parser_cfg_pkg::buf_idx_w-1:0];

    // Beats times beat size, nothing for reads or reserved size
    always_comb begin
        len_plus1 = {{(cw-4){1'b0}}, cmd_in.f.len} + 1'b1;
        unique case (cmd_in.f.size)
            frame_proto_pkg::size_byte: len_calc = len_plus1;
            frame_proto_pkg::size_half: len_calc = len_plus1 << 1;
            frame_proto_pkg::size_word: len_calc = len_plus1 << 2;
            default:                    len_calc = '0;
        endcase
        if (cmd_in.f.rw) len_calc = '0;
    end

    // Bad command outranks a CRC mismatch
    always_comb begin
        if (cmd.f.size == frame_proto_pkg::size_rsvd) begin
            crc_status = frame_proto_pkg::status_cmd_inv;
        end else if (rx_fifo_data != crc_calc) begin
            crc_status = frame_proto_pkg::status_crc_err;
        end else begin
            crc_status = frame_proto_pkg::status_ok;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            parser_cfg_pkg::idle: begin
                if (crc_clear) state_next = parser_cfg_pkg::cmd;
            end
            parser_cfg_pkg::cmd:   if (take) state_next = parser_cfg_pkg::addr0;
            parser_cfg_pkg::addr0: if (take) state_next = parser_cfg_pkg::addr1;
            parser_cfg_pkg::addr1: if (take) state_next = parser_cfg_pkg::addr2;
            parser_cfg_pkg::addr2: if (take) state_next = parser_cfg_pkg::addr3;
            parser_cfg_pkg::addr3: begin
                if (take) begin
                    // No payload goes straight to the CRC byte
                    state_next = (exp_len == '0) ? parser_cfg_pkg::crc_rx
                                                 : parser_cfg_pkg::data_rx;
                end
            end
            parser_cfg_pkg::data_rx: begin
                if (take && (data_count + 1'b1 == exp_len)) state_next = parser_cfg_pkg::crc_rx;
            end
            parser_cfg_pkg::crc_rx: if (take) state_next = parser_cfg_pkg::done;
            parser_cfg_pkg::done, parser_cfg_pkg::error: begin
                if (frame_consumed) state_next = parser_cfg_pkg::idle;
            end
            default: state_next = parser_cfg_pkg::idle;
        endcase
        // Starved receive state gives up
        if (frame_open && !take && timed_out) state_next = parser_cfg_pkg::error;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= parser_cfg_pkg::idle;
            frame_valid  <= 1'b0;
            frame_error  <= 1'b0;
            error_status <= frame_proto_pkg::status_ok;
            data_count   <= '0;
        end else begin
            state <= state_next;
            if (crc_clear) data_count <= '0; // New frame, empty payload
            if (buf_wr_en) data_count <= data_count + 1'b1;
            if (take && (state == parser_cfg_pkg::crc_rx)) begin
                error_status <= crc_status;
                frame_valid  <= (crc_status == frame_proto_pkg::status_ok);
                frame_error  <= (crc_status != frame_proto_pkg::status_ok);
            end
            if (state_next == parser_cfg_pkg::error && state != parser_cfg_pkg::error) begin
                error_status <= frame_proto_pkg::status_timeout;
                frame_error  <= 1'b1;
            end
            if (frame_consumed && !frame_open && parser_busy) begin
                frame_valid <= 1'b0; // Result released
                frame_error <= 1'b0;
            end
        end
    end

    // Frame fields, held until the next frame overwrites them
    always_ff @(posedge clk) begin
        if (take) begin
            unique case (state)
                parser_cfg_pkg::cmd: begin
                    cmd     <= cmd_in;
                    exp_len <= len_calc;
                end
                parser_cfg_pkg::addr0: addr[7:0]   <= rx_fifo_data; // Little endian
                parser_cfg_pkg::addr1: addr[15:8]  <= rx_fifo_data;
                parser_cfg_pkg::addr2: addr[23:16] <= rx_fifo_data;
                parser_cfg_pkg::addr3: addr[31:24] <= rx_fifo_data;
                default: ;
            endcase
        end
    end

    // Payload writes stay inside the length the command asked for
    a_wr_in_len: assert property (@(posedge clk) disable iff (rst)
        buf_wr_en |-> (data_count < exp_len));

    a_one_result: assert property (@(posedge clk) disable iff (rst)
        !(frame_valid && frame_error));

    a_valid_ok: assert property (@(posedge clk) disable iff (rst)
        frame_valid |-> (error_status == frame_proto_pkg::status_ok));

endmodule

/* logic/frame_parser.sv */
`timescale 1ns/1ps

module frame_parser #(
    parameter int timeout_clocks = 0 // Byte gap limit in clocks, 0 = off
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [7:0]                           rx_fifo_data,
    input  logic                                 rx_fifo_empty,
    output logic                                 rx_fifo_rd_en,
    output frame_proto_pkg::cmd_t                cmd,
    output logic [31:0]                          addr,
    output logic [parser_cfg_pkg::count_w-1:0]   data_count,
    output frame_proto_pkg::status_t             error_status,
    output logic                                 frame_valid,
    output logic                                 frame_error,
    input  logic                                 frame_consumed,
    output logic                                 parser_busy,
    input  logic [parser_cfg_pkg::buf_idx_w-1:0] data_rd_idx,
    output logic [7:0]                           data_rd_byte
);

    logic                                 crc_clear;
    logic                                 crc_en;
    logic [7:0]                           crc_value;  // Running CRC of the frame
    logic                                 buf_wr_en;
    logic [parser_cfg_pkg::buf_idx_w-1:0] buf_wr_idx;
    logic                                 frame_open;
    logic                                 timed_out;

    frame_parser_fsm frame_parser_fsm_inst (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .crc_clear      (crc_clear),
        .crc_en         (crc_en),
        .crc_calc       (crc_value),
        .buf_wr_en      (buf_wr_en),
        .buf_wr_idx     (buf_wr_idx),
        .frame_open     (frame_open),
        .timed_out      (timed_out),
        .cmd            (cmd),
        .addr           (addr),
        .data_count     (data_count),
        .error_status   (error_status),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .frame_consumed (frame_consumed),
        .parser_busy    (parser_busy)
    );

    // CRC fed straight from the FIFO byte
    crc8_calc crc8_calc_inst (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .data_in   (rx_fifo_data),
        .crc       (crc_value)
    );

    byte_gap_timer #(
        .timeout_clocks (timeout_clocks)
    ) byte_gap_timer_inst (
        .clk        (clk),
        .rst        (rst),
        .frame_open (frame_open),
        .fifo_empty (rx_fifo_empty),
        .timed_out  (timed_out)
    );

    frame_data_buffer frame_data_buffer_inst (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_idx  (buf_wr_idx),
        .wr_data (rx_fifo_data),
        .rd_idx  (data_rd_idx),
        .rd_data (data_rd_byte)
    );

endmodule

/* testbench/frame_tests.svh */
`ifndef FRAME_TESTS_SVH
`define FRAME_TESTS_SVH

// One host frame per row, payload is filled in by the test loop
typedef struct packed {
    logic [7:0]               cmd_byte;   // rw, inc, size[1:0], len[3:0]
    logic [31:0]              addr;
    logic [3:0]               junk;       // Non-start bytes queued ahead of A5h
    bit                       bad_crc;    // Send the CRC byte inverted
    bit                       cut;        // Frame ends before its CRC byte
    frame_proto_pkg::status_t exp_status;
    bit                       exp_valid;  // 1 = frame_valid, 0 = frame_error
} frame_test_t;

localparam int num_tests = 9;

localparam frame_test_t tests [num_tests] = '{
    '{8'h6F, 32'h1234_5678, 4'd0, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}, // Word x16
    '{8'hE3, 32'h0000_1000, 4'd0, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}, // Read
    '{8'h04, 32'hA000_0010, 4'd0, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}, // Byte x5
    '{8'h57, 32'h0000_2002, 4'd0, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}, // Half x8
    '{8'h63, 32'h4000_0000, 4'd0, 1'b1, 1'b0, frame_proto_pkg::status_crc_err, 1'b0},
    // Reserved size wins over the flipped CRC
    '{8'h32, 32'h8000_0003, 4'd0, 1'b1, 1'b0, frame_proto_pkg::status_cmd_inv, 1'b0},
    '{8'h21, 32'hC0DE_0004, 4'd3, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}, // Junk
    '{8'h12, 32'h0000_0100, 4'd0, 1'b0, 1'b1, frame_proto_pkg::status_timeout, 1'b0}, // Gap
    '{8'h45, 32'hFFFF_FFF0, 4'd0, 1'b0, 1'b0, frame_proto_pkg::status_ok,      1'b1}  // Recovery
};

`endif

/* testbench/tb_frame_parser.sv */
`timescale 1ns/1ps

module tb_frame_parser;

    localparam int timeout_clocks = 20;
    localparam int result_wait    = 2 * (70 + timeout_clocks); // Cycles per frame, max

    `include "frame_tests.svh"

    localparam int watchdog_ns = num_tests * (70 + timeout_clocks) * 10 * 4;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic [7:0]                           rx_fifo_data  = 8'h00;
    logic                                 rx_fifo_empty = 1'b1;
    logic                                 rx_fifo_rd_en;
    frame_proto_pkg::cmd_t                cmd;
    logic [31:0]                          addr;
    logic [parser_cfg_pkg::count_w-1:0]   data_count;
    frame_proto_pkg::status_t             error_status;
    logic                                 frame_valid;
    logic                                 frame_error;
    logic                                 frame_consumed;
    logic                                 parser_busy;
    logic [parser_cfg_pkg::buf_idx_w-1:0] data_rd_idx;
    logic [7:0]                           data_rd_byte;

    logic [7:0] fifo_q [$];        // Receive FIFO contents, head first
    logic       pop_pending = 1'b0; // Head is taken at the coming rising edge
    logic [7:0] exp_data [64];     // Payload of the frame in flight
    integer     seed = 32'h2e34;
    int         n_checks = 0;
    int         n_errors = 0;

    frame_parser #(
        .timeout_clocks (timeout_clocks)
    ) frame_parser_inst (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .cmd            (cmd),
        .addr           (addr),
        .data_count     (data_count),
        .error_status   (error_status),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .frame_consumed (frame_consumed),
        .parser_busy    (parser_busy),
        .data_rd_idx    (data_rd_idx),
        .data_rd_byte   (data_rd_byte)
    );

    always #5 clk = ~clk; // 10 ns period

    // FIFO model, updated on the falling edge
    always @(negedge clk) begin
        if (pop_pending) void'(fifo_q.pop_front()); // Taken at the last rising edge
        rx_fifo_empty = (fifo_q.size() == 0);
        rx_fifo_data  = (fifo_q.size() == 0) ? 8'h00 : fifo_q[0];
        #1;
        pop_pending = rx_fifo_rd_en; // Stable until the next rising edge
    end

    // CRC-8, poly 07h, one input bit at a time MSB first
    function automatic logic [7:0] crc8_update(logic [7:0] crc, logic [7:0] b);
        logic fb;
        for (int i = 7; i >= 0; i--) begin
            fb  = crc[7] ^ b[i];
            crc = {crc[6:0], 1'b0};
            if (fb) crc = crc ^ 8'h07;
        end
        return crc;
    endfunction

    // Payload bytes the command calls for
    function automatic logic [parser_cfg_pkg::count_w-1:0] payload_len(
        frame_proto_pkg::cmd_t c);
        logic [parser_cfg_pkg::count_w-1:0] beats;
        beats      = '0;
        beats[3:0] = c.f.len;
        beats      = beats + 1'b1; // len is beats minus one
        if (c.f.rw) return '0;     // Reads carry no data
        case (c.f.size)
            frame_proto_pkg::size_byte: return beats;
            frame_proto_pkg::size_half: return beats * 2;
            frame_proto_pkg::size_word: return beats * 4;
            default:                    return '0;
        endcase
    endfunction

    task automatic check_status(input frame_proto_pkg::status_t got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cmd(input frame_proto_pkg::cmd_t got, exp, input string what);
        n_checks++;
        if (got.raw !== exp.raw) begin
            n_errors++;
            $display("ERR %0d ns: %s got %h expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [parser_cfg_pkg::count_w-1:0] got, exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Build one frame from its row, queue it, check the result and release it
    task automatic run_test(input int t);
        frame_test_t           tc;
        frame_proto_pkg::cmd_t exp_cmd;
        logic [7:0]            frame_q [$];
        logic [7:0]            crc;
        logic [7:0]            b;
        logic [parser_cfg_pkg::count_w-1:0] exp_len;
        int                    n;
        int                    rnd;
        int                    wait_cyc;
        int                    errs_before;
        tc           = tests[t];
        exp_cmd.raw  = tc.cmd_byte;
        exp_len      = payload_len(exp_cmd);
        n            = int'(exp_len);
        errs_before  = n_errors;
        for (int j = 0; j < int'(tc.junk); j++) begin
            rnd = $random(seed);
            b   = (rnd[7:0] == frame_proto_pkg::sof_host) ? 8'h5A : rnd[7:0]; // Never A5h
            frame_q.push_back(b);
        end
        frame_q.push_back(frame_proto_pkg::sof_host);
        frame_q.push_back(tc.cmd_byte);
        crc = crc8_update(8'h00, tc.cmd_byte);
        for (int k = 0; k < 4; k++) begin
            frame_q.push_back(tc.addr[8*k +: 8]); // LSB first
            crc = crc8_update(crc, tc.addr[8*k +: 8]);
        end
        for (int i = 0; i < n; i++) begin
            rnd         = $random(seed);
            exp_data[i] = rnd[7:0];
            frame_q.push_back(rnd[7:0]);
            crc = crc8_update(crc, rnd[7:0]);
        end
        if (!tc.cut) frame_q.push_back(tc.bad_crc ? ~crc : crc);

        @(posedge clk); // Whole frame lands in the FIFO at once
        foreach (frame_q[i]) fifo_q.push_back(frame_q[i]);

        wait_cyc = 0;
        do begin
            @(negedge clk);
            wait_cyc++;
        end while (!frame_valid && !frame_error && wait_cyc < result_wait);

        if (!frame_valid && !frame_error) begin
            n_errors++;
            $display("test %0d: no frame_valid or frame_error within %0d cycles", t, result_wait);
        end else begin
            check_level(frame_valid, tc.exp_valid, "frame_valid");
            check_level(frame_error, !tc.exp_valid, "frame_error");
            check_level(parser_busy, 1'b1, "parser_busy");
            check_status(error_status, tc.exp_status, "error_status");
            check_cmd(cmd, exp_cmd, "cmd");
            check_addr(addr, tc.addr, "addr");
            check_count(data_count, exp_len, "data_count");
            if (tc.exp_valid) begin
                for (int i = 0; i < n; i++) begin
                    @(negedge clk);
                    data_rd_idx = i[parser_cfg_pkg::buf_idx_w-1:0];
                    @(posedge clk);
                    check_byte(data_rd_byte, exp_data[i], $sformatf("payload byte %0d", i));
                end
            end
        end

        @(negedge clk);
        frame_consumed = 1'b1; // One cycle release pulse
        @(negedge clk);
        frame_consumed = 1'b0;
        check_level(frame_valid, 1'b0, "frame_valid after release");
        check_level(frame_error, 1'b0, "frame_error after release");
        check_level(parser_busy, 1'b0, "parser_busy after release");

        $display("test %0d cmd %h addr %h len %0d: %s", t, tc.cmd_byte, tc.addr, exp_len,
                 (n_errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        rst            = 1'b1;
        frame_consumed = 1'b0;
        data_rd_idx    = '0;
        repeat (8) @(negedge clk); // 8 rising edges in reset
        rst = 1'b0;
        // Quiet outputs straight out of reset
        check_level(rx_fifo_rd_en, 1'b0, "rx_fifo_rd_en after reset");
        check_level(frame_valid, 1'b0, "frame_valid after reset");
        check_level(frame_error, 1'b0, "frame_error after reset");
        check_level(parser_busy, 1'b0, "parser_busy after reset");
        $display("reset state: %s", (n_errors == 0) ? "ok" : "FAILED");
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Hang guard sized from the table length
    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the test loop did not finish", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* sim.f */
+incdir+testbench
logic/frame_proto_pkg.sv
logic/parser_cfg_pkg.sv
logic/crc8_calc.sv
logic/byte_gap_timer.sv
logic/frame_data_buffer.sv
logic/frame_parser_fsm.sv
logic/frame_parser.sv
testbench/tb_frame_parser.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vtb_frame_parser
	@out=$$(./obj_dir/Vtb_frame_parser); echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

obj_dir/Vtb_frame_parser: sim.f logic/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert -j 0 --top-module tb_frame_parser \
		-f sim.f -o Vtb_frame_parser

lint:
	verilator --lint-only --timing --top-module tb_frame_parser -f sim.f
	verilator --lint-only --top-module frame_parser logic/frame_proto_pkg.sv \
		logic/parser_cfg_pkg.sv logic/crc8_calc.sv logic/byte_gap_timer.sv \
		logic/frame_data_buffer.sv logic/frame_parser_fsm.sv logic/frame_parser.sv

clean:
	rm -rf obj_dir
